//--- exu_cfg_pkg.sv
// Datapath and branch predictor sizes for the execute unit
// Operand, PC and branch offset widths
// Global history, BTB index and BTB tag widths
// Bypass source count and one-hot positions
`default_nettype none

package exu_cfg_pkg;

   // Datapath
   localparam int XLEN        = 32;
   localparam int PC_W        = 31;   // Halfword PC, bits 31:1
   localparam int BR_IMM_W    = 12;   // Branch offset in halfwords

   // Branch predictor
   localparam int GHR_W       = 8;
   localparam int BTB_INDEX_W = 8;
   localparam int BTB_TAG_W   = 5;

   // Bypass sources in the one-hot select
   localparam int BYP_N       = 4;
   localparam int BYP_R       = 0;    // R-stage result
   localparam int BYP_M       = 1;    // M-stage load result
   localparam int BYP_X       = 2;    // X-stage result
   localparam int BYP_NB      = 3;    // Non-blocking load data

endpackage

`default_nettype wire

//--- exu_op_pkg.sv
// ALU and branch operation encodings
// Branch group test and branch condition helper
`default_nettype none

package exu_op_pkg;

   // Bit 4 set marks the branch group
   typedef enum logic [4:0] {
      ADD  = 5'h00,
      SUB  = 5'h01,
      AND  = 5'h02,
      OR   = 5'h03,
      XOR  = 5'h04,
      SLT  = 5'h05,
      SLTU = 5'h06,
      SLL  = 5'h07,
      SRL  = 5'h08,
      SRA  = 5'h09,
      BEQ  = 5'h10,
      BNE  = 5'h11,
      BLT  = 5'h12,
      BGE  = 5'h13,
      BLTU = 5'h14,
      BGEU = 5'h15,
      JAL  = 5'h16    // Always taken
   } alu_op_e;

   function automatic logic OP_IS_BRANCH(input alu_op_e op);
      return op >= BEQ;
   endfunction

   // Actual direction of a branch, zero for ALU operations
   function automatic logic br_cond(input alu_op_e                    op,
                                    input logic [exu_cfg_pkg::XLEN-1:0] a,
                                    input logic [exu_cfg_pkg::XLEN-1:0] b);
      case (op)
         BEQ:     return a == b;
         BNE:     return a != b;
         BLT:     return $signed(a) < $signed(b);
         BGE:     return $signed(a) >= $signed(b);
         BLTU:    return a < b;
         BGEU:    return a >= b;
         JAL:     return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

endpackage

`default_nettype wire

//--- exu_operand_sel.sv
// D-stage operand select
// OR-combined one-hot bypass data
// rs1 and rs2 priority muxes over bypass, PC, immediate and GPR
`timescale 1ns/10ps
`default_nettype none

module exu_operand_sel (
   input  logic                                  clk,
   input  logic                                  i_rst_n,
   input  logic [exu_cfg_pkg::BYP_N-1:0]         i_rs1_byp_sel_d,   // One-hot or zero
   input  logic [exu_cfg_pkg::BYP_N-1:0]         i_rs2_byp_sel_d,   // One-hot or zero
   input  logic [exu_cfg_pkg::XLEN-1:0]          i_result_r,
   input  logic [exu_cfg_pkg::XLEN-1:0]          i_lsu_result_m,
   input  logic [exu_cfg_pkg::XLEN-1:0]          i_result_x,        // Own X result fed back
   input  logic [exu_cfg_pkg::XLEN-1:0]          i_nb_load_data,
   input  logic [exu_cfg_pkg::XLEN-1:0]          i_gpr_rs1_d,
   input  logic [exu_cfg_pkg::XLEN-1:0]          i_gpr_rs2_d,
   input  logic                                  i_rs1_en_d,
   input  logic                                  i_rs2_en_d,
   input  logic [exu_cfg_pkg::XLEN-1:0]          i_imm_d,
   input  logic                                  i_use_imm_d,
   input  logic                                  i_select_pc_d,     // Jumps take PC on rs1
   input  logic [exu_cfg_pkg::PC_W:1]            i_pc_d,
   output logic [exu_cfg_pkg::XLEN-1:0]          o_rs1_d,
   output logic [exu_cfg_pkg::XLEN-1:0]          o_rs2_d
);

   function automatic logic [exu_cfg_pkg::XLEN-1:0] byp_data(
      input logic [exu_cfg_pkg::BYP_N-1:0] sel);
      return ({exu_cfg_pkg::XLEN{sel[exu_cfg_pkg::BYP_R]}}  & i_result_r)     |
             ({exu_cfg_pkg::XLEN{sel[exu_cfg_pkg::BYP_M]}}  & i_lsu_result_m) |
             ({exu_cfg_pkg::XLEN{sel[exu_cfg_pkg::BYP_X]}}  & i_result_x)     |
             ({exu_cfg_pkg::XLEN{sel[exu_cfg_pkg::BYP_NB]}} & i_nb_load_data);
   endfunction

   always_comb begin
      if (|i_rs1_byp_sel_d)   o_rs1_d = byp_data(i_rs1_byp_sel_d);
      else if (i_select_pc_d) o_rs1_d = {i_pc_d, 1'b0};
      else if (i_rs1_en_d)    o_rs1_d = i_gpr_rs1_d;
      else                    o_rs1_d = '0;                      // x0 or unused
   end

   always_comb begin
      if (|i_rs2_byp_sel_d)   o_rs2_d = byp_data(i_rs2_byp_sel_d);
      else if (i_use_imm_d)   o_rs2_d = i_imm_d;
      else if (i_rs2_en_d)    o_rs2_d = i_gpr_rs2_d;
      else                    o_rs2_d = '0;
   end

   // Decoder must never pick two bypass sources at once
   a_byp_onehot: assert property (@(posedge clk) disable iff (!i_rst_n)
      $onehot0(i_rs1_byp_sel_d) && $onehot0(i_rs2_byp_sel_d))
      else $error("bypass select not one-hot");

endmodule

`default_nettype wire

//--- exu_alu.sv
// X stage of the execute unit
// Operand, operation, PC and prediction registers with the kill rule
// Integer ALU with the link value for branches and jumps
// Branch compare, target, mispredict and final flush select
`timescale 1ns/10ps
`default_nettype none

module exu_alu (
   input  logic                               clk,
   input  logic                               i_rst_n,
   input  logic                               i_hold,            // Freeze X and R
   input  logic                               i_valid_d,
   input  exu_op_pkg::alu_op_e                i_op_d,
   input  logic [exu_cfg_pkg::XLEN-1:0]       i_rs1_d,
   input  logic [exu_cfg_pkg::XLEN-1:0]       i_rs2_d,
   input  logic [exu_cfg_pkg::PC_W:1]         i_pc_d,
   input  logic [exu_cfg_pkg::BR_IMM_W:1]     i_br_imm_d,        // Offset in halfwords
   input  logic                               i_pred_taken_d,
   input  logic [exu_cfg_pkg::PC_W:1]         i_pred_target_d,
   input  logic                               i_flush_lower_r,   // Commit flush wins
   input  logic [exu_cfg_pkg::PC_W:1]         i_flush_path_r,
   output logic                               o_valid_x,
   output logic [exu_cfg_pkg::XLEN-1:0]       o_result_x,
   output logic [exu_cfg_pkg::PC_W:1]         o_pc_x,
   output logic                               o_branch_x,
   output logic                               o_taken_x,         // Actual direction
   output logic                               o_mp_x,            // Valid mispredict at X
   output logic                               o_flush_final,
   output logic [exu_cfg_pkg::PC_W:1]         o_flush_path
);

   localparam int SHAMT_W = $clog2(exu_cfg_pkg::XLEN);

   exu_op_pkg::alu_op_e                  op_x;
   logic [exu_cfg_pkg::XLEN-1:0]         a_x;
   logic [exu_cfg_pkg::XLEN-1:0]         b_x;
   logic [exu_cfg_pkg::BR_IMM_W:1]       br_imm_x;
   logic                                 pred_taken_x;
   logic [exu_cfg_pkg::PC_W:1]           pred_target_x;
   logic [exu_cfg_pkg::XLEN-1:0]         pc_full_x;
   logic [exu_cfg_pkg::XLEN-1:0]         pc_next_x;
   logic [exu_cfg_pkg::XLEN-1:0]         br_off_x;
   logic [exu_cfg_pkg::XLEN-1:0]         target_x;
   logic [SHAMT_W-1:0]                   shamt_x;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_valid_x <= 1'b0;
      end else if (!i_hold) begin
         o_valid_x <= i_valid_d & ~o_flush_final & ~i_flush_lower_r;   // Kill on any flush
      end
   end

   always_ff @(posedge clk) begin
      if (!i_hold) begin
         op_x          <= i_op_d;
         a_x           <= i_rs1_d;
         b_x           <= i_rs2_d;
         o_pc_x        <= i_pc_d;
         br_imm_x      <= i_br_imm_d;
         pred_taken_x  <= i_pred_taken_d;
         pred_target_x <= i_pred_target_d;
      end
   end

   assign pc_full_x = {o_pc_x, 1'b0};
   assign pc_next_x = pc_full_x + 4;                               // Link value
   assign shamt_x   = b_x[SHAMT_W-1:0];

   always_comb begin
      case (op_x)
         exu_op_pkg::ADD:  o_result_x = a_x + b_x;
         exu_op_pkg::SUB:  o_result_x = a_x - b_x;
         exu_op_pkg::AND:  o_result_x = a_x & b_x;
         exu_op_pkg::OR:   o_result_x = a_x | b_x;
         exu_op_pkg::XOR:  o_result_x = a_x ^ b_x;
         exu_op_pkg::SLT:  o_result_x = {{(exu_cfg_pkg::XLEN-1){1'b0}},
                                         $signed(a_x) < $signed(b_x)};
         exu_op_pkg::SLTU: o_result_x = {{(exu_cfg_pkg::XLEN-1){1'b0}}, a_x < b_x};
         exu_op_pkg::SLL:  o_result_x = a_x << shamt_x;
         exu_op_pkg::SRL:  o_result_x = a_x >> shamt_x;
         exu_op_pkg::SRA:  o_result_x = $signed(a_x) >>> shamt_x;
         default:          o_result_x = pc_next_x;                 // Branches and jumps
      endcase
   end

   // Target is PC plus twice the sign-extended offset
   assign br_off_x = {{(exu_cfg_pkg::XLEN-exu_cfg_pkg::BR_IMM_W-1){br_imm_x[exu_cfg_pkg::BR_IMM_W]}},
                      br_imm_x, 1'b0};
   assign target_x = pc_full_x + br_off_x;

   assign o_branch_x = exu_op_pkg::OP_IS_BRANCH(op_x);
   assign o_taken_x  = o_branch_x & exu_op_pkg::br_cond(op_x, a_x, b_x);

   // Wrong direction, or taken to the wrong place
   assign o_mp_x = o_valid_x & o_branch_x &
                   ((o_taken_x ^ pred_taken_x) |
                    (o_taken_x & (pred_target_x != target_x[exu_cfg_pkg::XLEN-1:1])));

   assign o_flush_final = ~i_hold & (i_flush_lower_r | o_mp_x);
   assign o_flush_path  = i_flush_lower_r ? i_flush_path_r                      :
                          o_taken_x       ? target_x[exu_cfg_pkg::XLEN-1:1]     :
                                            pc_next_x[exu_cfg_pkg::XLEN-1:1];

   // A held cycle flushes nothing
   a_hold_noflush: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_hold |-> !o_flush_final)
      else $error("flush raised under hold");

endmodule

`default_nettype wire

//--- exu_branch_retire.sv
// R stage branch retire
// Prediction index, tag and history carried from D through X
// R-stage branch report to the decoder
// Global history of actual outcomes and mispredict packet
`timescale 1ns/10ps
`default_nettype none

module exu_branch_retire (
   input  logic                                  clk,
   input  logic                                  i_rst_n,
   input  logic                                  i_hold,
   input  logic                                  i_flush_lower_r,
   input  logic                                  i_valid_x,
   input  logic                                  i_branch_x,
   input  logic                                  i_taken_x,
   input  logic                                  i_mp_x,
   input  logic [exu_cfg_pkg::BTB_INDEX_W-1:0]   i_pred_index_d,
   input  logic [exu_cfg_pkg::BTB_TAG_W-1:0]     i_pred_btag_d,
   input  logic [exu_cfg_pkg::GHR_W-1:0]         i_pred_fghr_d,
   output logic                                  o_br_valid_r,
   output logic                                  o_br_mp_r,
   output logic                                  o_br_taken_r,
   output logic [exu_cfg_pkg::BTB_INDEX_W-1:0]   o_br_index_r,
   output logic [exu_cfg_pkg::GHR_W-1:0]         o_br_fghr_r,
   output logic                                  o_mp_valid,
   output logic [exu_cfg_pkg::BTB_INDEX_W-1:0]   o_mp_index,
   output logic [exu_cfg_pkg::BTB_TAG_W-1:0]     o_mp_btag,
   output logic [exu_cfg_pkg::GHR_W-1:0]         o_mp_eghr,      // History at prediction
   output logic [exu_cfg_pkg::GHR_W-1:0]         o_mp_fghr       // History of outcomes
);

   logic [exu_cfg_pkg::BTB_INDEX_W-1:0]   index_x;
   logic [exu_cfg_pkg::BTB_TAG_W-1:0]     btag_x;
   logic [exu_cfg_pkg::GHR_W-1:0]         fghr_x;
   logic [exu_cfg_pkg::GHR_W-1:0]         ghr;
   logic                                  retire_x;

   // Valid branch leaving X for R this edge
   assign retire_x = ~i_hold & i_valid_x & i_branch_x & ~i_flush_lower_r;

   // Same edge and enable as the X registers in the ALU
   always_ff @(posedge clk) begin
      if (!i_hold) begin
         index_x <= i_pred_index_d;
         btag_x  <= i_pred_btag_d;
         fghr_x  <= i_pred_fghr_d;
      end
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_br_valid_r <= 1'b0;
         o_br_mp_r    <= 1'b0;
         ghr          <= '0;
      end else if (!i_hold) begin
         o_br_valid_r <= i_valid_x & i_branch_x & ~i_flush_lower_r;
         o_br_mp_r    <= i_valid_x & i_branch_x & i_mp_x & ~i_flush_lower_r;
         if (retire_x) begin
            ghr <= {ghr[exu_cfg_pkg::GHR_W-2:0], i_taken_x};   // Shift in actual outcome
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!i_hold) begin
         o_br_taken_r <= i_taken_x;
         o_br_index_r <= index_x;
         o_br_fghr_r  <= fghr_x;
      end
   end

   // Mispredict packet is zero unless X mispredicted
   assign o_mp_valid = i_mp_x;
   assign o_mp_index = i_mp_x ? index_x : '0;
   assign o_mp_btag  = i_mp_x ? btag_x  : '0;
   assign o_mp_eghr  = i_mp_x ? fghr_x  : '0;
   assign o_mp_fghr  = ghr;

   a_mp_has_valid: assert property (@(posedge clk) disable iff (!i_rst_n)
      o_br_mp_r |-> o_br_valid_r)
      else $error("R-stage mispredict without a valid branch");

endmodule

`default_nettype wire

//--- exu_top.sv
// Integer execute unit top level
// D-stage operand select, X-stage ALU and branch resolution
// R-stage branch retire, X result looped back to the bypass
`timescale 1ns/10ps
`default_nettype none

module exu_top (
   input  logic                                  clk,
   input  logic                                  i_rst_n,
   input  logic                                  i_hold,
   input  logic                                  i_valid_d,
   input  exu_op_pkg::alu_op_e                   i_op_d,
   input  logic [exu_cfg_pkg::PC_W:1]            i_pc_d,
   input  logic [exu_cfg_pkg::BR_IMM_W:1]        i_br_imm_d,
   input  logic [exu_cfg_pkg::XLEN-1:0]          i_gpr_rs1_d,
   input  logic [exu_cfg_pkg::XLEN-1:0]          i_gpr_rs2_d,
   input  logic                                  i_rs1_en_d,
   input  logic                                  i_rs2_en_d,
   input  logic [exu_cfg_pkg::XLEN-1:0]          i_imm_d,
   input  logic                                  i_use_imm_d,
   input  logic                                  i_select_pc_d,
   input  logic [exu_cfg_pkg::BYP_N-1:0]         i_rs1_byp_sel_d,
   input  logic [exu_cfg_pkg::BYP_N-1:0]         i_rs2_byp_sel_d,
   input  logic                                  i_pred_taken_d,
   input  logic [exu_cfg_pkg::PC_W:1]            i_pred_target_d,
   input  logic [exu_cfg_pkg::BTB_INDEX_W-1:0]   i_pred_index_d,
   input  logic [exu_cfg_pkg::BTB_TAG_W-1:0]     i_pred_btag_d,
   input  logic [exu_cfg_pkg::GHR_W-1:0]         i_pred_fghr_d,
   input  logic [exu_cfg_pkg::XLEN-1:0]          i_result_r,
   input  logic [exu_cfg_pkg::XLEN-1:0]          i_lsu_result_m,
   input  logic [exu_cfg_pkg::XLEN-1:0]          i_nb_load_data,
   input  logic                                  i_flush_lower_r,
   input  logic [exu_cfg_pkg::PC_W:1]            i_flush_path_r,
   output logic [exu_cfg_pkg::XLEN-1:0]          o_result_x,
   output logic [exu_cfg_pkg::PC_W:1]            o_pc_x,
   output logic                                  o_flush_final,
   output logic [exu_cfg_pkg::PC_W:1]            o_flush_path,
   output logic                                  o_br_valid_r,
   output logic                                  o_br_mp_r,
   output logic                                  o_br_taken_r,
   output logic [exu_cfg_pkg::BTB_INDEX_W-1:0]   o_br_index_r,
   output logic [exu_cfg_pkg::GHR_W-1:0]         o_br_fghr_r,
   output logic                                  o_mp_valid,
   output logic [exu_cfg_pkg::BTB_INDEX_W-1:0]   o_mp_index,
   output logic [exu_cfg_pkg::BTB_TAG_W-1:0]     o_mp_btag,
   output logic [exu_cfg_pkg::GHR_W-1:0]         o_mp_eghr,
   output logic [exu_cfg_pkg::GHR_W-1:0]         o_mp_fghr
);

   logic [exu_cfg_pkg::XLEN-1:0]   rs1_d;
   logic [exu_cfg_pkg::XLEN-1:0]   rs2_d;
   logic                           valid_x;
   logic                           branch_x;
   logic                           taken_x;
   logic                           mp_x;

   exu_operand_sel u_operand_sel (
      .clk             (clk),
      .i_rst_n         (i_rst_n),
      .i_rs1_byp_sel_d (i_rs1_byp_sel_d),
      .i_rs2_byp_sel_d (i_rs2_byp_sel_d),
      .i_result_r      (i_result_r),
      .i_lsu_result_m  (i_lsu_result_m),
      .i_result_x      (o_result_x),            // X-stage bypass
      .i_nb_load_data  (i_nb_load_data),
      .i_gpr_rs1_d     (i_gpr_rs1_d),
      .i_gpr_rs2_d     (i_gpr_rs2_d),
      .i_rs1_en_d      (i_rs1_en_d),
      .i_rs2_en_d      (i_rs2_en_d),
      .i_imm_d         (i_imm_d),
      .i_use_imm_d     (i_use_imm_d),
      .i_select_pc_d   (i_select_pc_d),
      .i_pc_d          (i_pc_d),
      .o_rs1_d         (rs1_d),
      .o_rs2_d         (rs2_d)
   );

   exu_alu u_alu (
      .clk             (clk),
      .i_rst_n         (i_rst_n),
      .i_hold          (i_hold),
      .i_valid_d       (i_valid_d),
      .i_op_d          (i_op_d),
      .i_rs1_d         (rs1_d),
      .i_rs2_d         (rs2_d),
      .i_pc_d          (i_pc_d),
      .i_br_imm_d      (i_br_imm_d),
      .i_pred_taken_d  (i_pred_taken_d),
      .i_pred_target_d (i_pred_target_d),
      .i_flush_lower_r (i_flush_lower_r),
      .i_flush_path_r  (i_flush_path_r),
      .o_valid_x       (valid_x),
      .o_result_x      (o_result_x),
      .o_pc_x          (o_pc_x),
      .o_branch_x      (branch_x),
      .o_taken_x       (taken_x),
      .o_mp_x          (mp_x),
      .o_flush_final   (o_flush_final),
      .o_flush_path    (o_flush_path)
   );

   exu_branch_retire u_branch_retire (
      .clk             (clk),
      .i_rst_n         (i_rst_n),
      .i_hold          (i_hold),
      .i_flush_lower_r (i_flush_lower_r),
      .i_valid_x       (valid_x),
      .i_branch_x      (branch_x),
      .i_taken_x       (taken_x),
      .i_mp_x          (mp_x),
      .i_pred_index_d  (i_pred_index_d),
      .i_pred_btag_d   (i_pred_btag_d),
      .i_pred_fghr_d   (i_pred_fghr_d),
      .o_br_valid_r    (o_br_valid_r),
      .o_br_mp_r       (o_br_mp_r),
      .o_br_taken_r    (o_br_taken_r),
      .o_br_index_r    (o_br_index_r),
      .o_br_fghr_r     (o_br_fghr_r),
      .o_mp_valid      (o_mp_valid),
      .o_mp_index      (o_mp_index),
      .o_mp_btag       (o_mp_btag),
      .o_mp_eghr       (o_mp_eghr),
      .o_mp_fghr       (o_mp_fghr)
   );

endmodule

`default_nettype wire

//--- tb_exu_top.sv
// Testbench for the integer execute unit
// Clock, reset and xorshift stimulus over ALU, bypass, branch, flush and hold
// Cycle reference model of X and R compared by concurrent assertions
// Watchdog sized from the number of test cycles
`timescale 1ns/10ps
`default_nettype none

module tb_exu_top;

   localparam int CLK_PERIOD = 40;
   localparam int RST_CYCLES = 16;
   localparam int N_PHASE    = 250;                           // Cycles per test
   localparam int N_TESTS    = 5;
   localparam int TIMEOUT    = (RST_CYCLES + N_TESTS * N_PHASE + 100) * CLK_PERIOD;
   localparam int XL         = exu_cfg_pkg::XLEN;
   localparam int PW         = exu_cfg_pkg::PC_W;
   localparam int IW         = exu_cfg_pkg::BR_IMM_W;

   logic clk = 1'b0;
   logic i_rst_n, i_hold, i_valid_d, i_rs1_en_d, i_rs2_en_d, i_use_imm_d, i_select_pc_d;
   logic i_pred_taken_d, i_flush_lower_r;
   exu_op_pkg::alu_op_e                   i_op_d;
   logic [PW:1]                           i_pc_d, i_pred_target_d, i_flush_path_r;
   logic [IW:1]                           i_br_imm_d;
   logic [XL-1:0]                         i_gpr_rs1_d, i_gpr_rs2_d, i_imm_d;
   logic [XL-1:0]                         i_result_r, i_lsu_result_m, i_nb_load_data;
   logic [exu_cfg_pkg::BYP_N-1:0]         i_rs1_byp_sel_d, i_rs2_byp_sel_d;
   logic [exu_cfg_pkg::BTB_INDEX_W-1:0]   i_pred_index_d, o_br_index_r, o_mp_index;
   logic [exu_cfg_pkg::BTB_TAG_W-1:0]     i_pred_btag_d, o_mp_btag;
   logic [exu_cfg_pkg::GHR_W-1:0]         i_pred_fghr_d, o_br_fghr_r, o_mp_eghr, o_mp_fghr;
   logic [XL-1:0]                         o_result_x;
   logic [PW:1]                           o_pc_x, o_flush_path;
   logic o_flush_final, o_br_valid_r, o_br_mp_r, o_br_taken_r, o_mp_valid;

   // Reference model state
   exu_op_pkg::alu_op_e                   m_op;
   logic [XL-1:0]                         m_a, m_b, m_result, m_target;
   logic [PW:1]                           m_pc, m_pred_target, m_path;
   logic [IW:1]                           m_imm;
   logic [exu_cfg_pkg::BTB_INDEX_W-1:0]   m_index, m_br_index_r;
   logic [exu_cfg_pkg::BTB_TAG_W-1:0]     m_btag;
   logic [exu_cfg_pkg::GHR_W-1:0]         m_fghr, m_br_fghr_r, m_ghr;
   logic m_valid_x, m_pred_taken, m_branch, m_taken, m_mp, m_flush;
   logic m_br_valid_r, m_br_mp_r, m_br_taken_r;

   logic [31:0] rng_state = 32'hd680b5fa;
   string       test_name = "reset";

   exu_top u_exu_top (.*);

   always #(CLK_PERIOD / 2) clk = ~clk;

   function automatic logic [31:0] next_rand();
      rng_state ^= rng_state << 13;
      rng_state ^= rng_state >> 17;
      rng_state ^= rng_state << 5;
      return rng_state;
   endfunction

   function automatic logic chance(input int pct);
      return (next_rand() % 100) < pct;
   endfunction

   // Bypass first, then the alternate source, then the register file
   function automatic logic [XL-1:0] operand_pick(input logic [3:0] sel, input logic alt_en,
         input logic [XL-1:0] alt, input logic gpr_en, input logic [XL-1:0] gpr);
      if (sel[exu_cfg_pkg::BYP_R])  return i_result_r;
      if (sel[exu_cfg_pkg::BYP_M])  return i_lsu_result_m;
      if (sel[exu_cfg_pkg::BYP_X])  return m_result;
      if (sel[exu_cfg_pkg::BYP_NB]) return i_nb_load_data;
      if (alt_en)                   return alt;
      return gpr_en ? gpr : '0;
   endfunction

   function automatic logic signed_less(input logic [XL-1:0] a, input logic [XL-1:0] b);
      return (a[XL-1] != b[XL-1]) ? a[XL-1] : (a < b);
   endfunction

   function automatic logic [XL-1:0] alu_model(input exu_op_pkg::alu_op_e op,
         input logic [XL-1:0] a, input logic [XL-1:0] b, input logic [XL-1:0] pc);
      logic [2*XL-1:0] ext;
      ext = {{XL{a[XL-1]}}, a} >> b[4:0];                     // Sign fill for SRA
      case (op)
         exu_op_pkg::ADD:  return a + b;
         exu_op_pkg::SUB:  return a + ~b + 1;
         exu_op_pkg::AND:  return a & b;
         exu_op_pkg::OR:   return a | b;
         exu_op_pkg::XOR:  return a ^ b;
         exu_op_pkg::SLT:  return {{(XL-1){1'b0}}, signed_less(a, b)};
         exu_op_pkg::SLTU: return {{(XL-1){1'b0}}, a < b};
         exu_op_pkg::SLL:  return a << b[4:0];
         exu_op_pkg::SRL:  return a >> b[4:0];
         exu_op_pkg::SRA:  return ext[XL-1:0];
         default:          return pc + 32'd4;                  // Link value
      endcase
   endfunction

   function automatic logic cond_model(input exu_op_pkg::alu_op_e op,
         input logic [XL-1:0] a, input logic [XL-1:0] b);
      case (op)
         exu_op_pkg::BEQ:  return a == b;
         exu_op_pkg::BNE:  return a != b;
         exu_op_pkg::BLT:  return signed_less(a, b);
         exu_op_pkg::BGE:  return !signed_less(a, b);
         exu_op_pkg::BLTU: return a < b;
         exu_op_pkg::BGEU: return !(a < b);
         exu_op_pkg::JAL:  return 1'b1;
         default:          return 1'b0;
      endcase
   endfunction

   always_comb begin
      m_branch = m_op inside {exu_op_pkg::BEQ, exu_op_pkg::BNE, exu_op_pkg::BLT,
                              exu_op_pkg::BGE, exu_op_pkg::BLTU, exu_op_pkg::BGEU,
                              exu_op_pkg::JAL};
      m_result = alu_model(m_op, m_a, m_b, {m_pc, 1'b0});
      m_taken  = m_branch && cond_model(m_op, m_a, m_b);
      m_target = {m_pc, 1'b0} + {{(XL-IW-1){m_imm[IW]}}, m_imm, 1'b0};
      m_mp     = m_valid_x && m_branch && ((m_taken != m_pred_taken) ||
                 (m_taken && m_pred_target != m_target[XL-1:1]));
      m_flush  = !i_hold && (i_flush_lower_r || m_mp);
      m_path   = i_flush_lower_r ? i_flush_path_r :
                 m_taken ? m_target[XL-1:1] : m_result[XL-1:1];
   end

   always @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         m_valid_x    <= 1'b0;
         m_br_valid_r <= 1'b0;
         m_br_mp_r    <= 1'b0;
         m_ghr        <= '0;
      end else if (!i_hold) begin
         m_valid_x    <= i_valid_d && !m_flush && !i_flush_lower_r;
         m_br_valid_r <= m_valid_x && m_branch && !i_flush_lower_r;
         m_br_mp_r    <= m_mp && !i_flush_lower_r;
         if (m_valid_x && m_branch && !i_flush_lower_r)
            m_ghr <= {m_ghr[exu_cfg_pkg::GHR_W-2:0], m_taken};
      end
   end

   always @(posedge clk) begin
      if (!i_hold) begin
         m_op          <= i_op_d;
         m_a           <= operand_pick(i_rs1_byp_sel_d, i_select_pc_d, {i_pc_d, 1'b0},
                                       i_rs1_en_d, i_gpr_rs1_d);
         m_b           <= operand_pick(i_rs2_byp_sel_d, i_use_imm_d, i_imm_d,
                                       i_rs2_en_d, i_gpr_rs2_d);
         m_pc          <= i_pc_d;
         m_imm         <= i_br_imm_d;
         m_pred_taken  <= i_pred_taken_d;
         m_pred_target <= i_pred_target_d;
         m_index       <= i_pred_index_d;
         m_btag        <= i_pred_btag_d;
         m_fghr        <= i_pred_fghr_d;
         m_br_taken_r  <= m_taken;
         m_br_index_r  <= m_index;
         m_br_fghr_r   <= m_fghr;
      end
   end

   task automatic report_mismatch(input string field, input logic [31:0] expected,
                                  input logic [31:0] actual);
      $display("FAIL %s %s: expected %h actual %h", test_name, field, expected, actual);
      $display("Simulation failed");
      $fatal(1, "value mismatch");
   endtask

   task automatic report_failure(input string what);
      $display("FAIL %s: %s", test_name, what);
      $display("Simulation failed");
      $fatal(1, "check failed");
   endtask

   a_result: assert property (@(posedge clk) disable iff (!i_rst_n)
      m_valid_x |-> o_result_x == m_result)
      else report_mismatch("o_result_x", 32'($sampled(m_result)),
                           32'($sampled(o_result_x)));
   a_pc: assert property (@(posedge clk) disable iff (!i_rst_n)
      m_valid_x |-> o_pc_x == m_pc)
      else report_mismatch("o_pc_x", 32'($sampled(m_pc)), 32'($sampled(o_pc_x)));
   a_flush: assert property (@(posedge clk) disable iff (!i_rst_n) o_flush_final == m_flush)
      else report_mismatch("o_flush_final", 32'($sampled(m_flush)),
                           32'($sampled(o_flush_final)));
   a_flush_path: assert property (@(posedge clk) disable iff (!i_rst_n)
      m_flush |-> o_flush_path == m_path)
      else report_mismatch("o_flush_path", 32'($sampled(m_path)),
                           32'($sampled(o_flush_path)));
   a_r_valid: assert property (@(posedge clk) disable iff (!i_rst_n)
      o_br_valid_r == m_br_valid_r && o_br_mp_r == m_br_mp_r)
      else report_mismatch("br_valid_mp", 32'($sampled({m_br_valid_r, m_br_mp_r})),
                           32'($sampled({o_br_valid_r, o_br_mp_r})));
   a_r_data: assert property (@(posedge clk) disable iff (!i_rst_n)
      m_br_valid_r |-> {o_br_taken_r, o_br_index_r, o_br_fghr_r} ==
                       {m_br_taken_r, m_br_index_r, m_br_fghr_r})
      else report_mismatch("br_report",
                           32'($sampled({m_br_taken_r, m_br_index_r, m_br_fghr_r})),
                           32'($sampled({o_br_taken_r, o_br_index_r, o_br_fghr_r})));
   // Packet is the prediction of the mispredicted branch, zero otherwise
   a_mp_packet: assert property (@(posedge clk) disable iff (!i_rst_n)
      {o_mp_valid, o_mp_index, o_mp_btag, o_mp_eghr} ==
      (m_mp ? {1'b1, m_index, m_btag, m_fghr} : '0))
      else report_mismatch("mp_packet",
                           32'($sampled(m_mp ? {1'b1, m_index, m_btag, m_fghr} : '0)),
                           32'($sampled({o_mp_valid, o_mp_index, o_mp_btag, o_mp_eghr})));
   a_history: assert property (@(posedge clk) disable iff (!i_rst_n) o_mp_fghr == m_ghr)
      else report_mismatch("o_mp_fghr", 32'($sampled(m_ghr)), 32'($sampled(o_mp_fghr)));
   a_hold_noflush: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_hold |-> !o_flush_final)
      else report_failure("o_flush_final was high while i_hold was high");
   a_hold_frozen: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_hold |=> $stable({o_result_x, o_pc_x, o_br_valid_r, o_br_mp_r, o_br_taken_r,
                          o_br_index_r, o_br_fghr_r, o_mp_valid, o_mp_index, o_mp_btag,
                          o_mp_eghr, o_mp_fghr}))
      else report_failure("X or R outputs changed across a held cycle");

   // One cycle of stimulus; op_mode 0 is ALU, 1 is branch, 2 is either
   task automatic issue_cycle(input int op_mode, input int byp_pct, input int flush_pct,
                              input int hold_pct);
      logic [31:0] r;
      @(posedge clk);
      #2;
      if (chance(hold_pct)) begin
         i_hold = 1'b1;                                        // D inputs stay put
         return;
      end
      i_hold    = 1'b0;
      i_valid_d = chance(90);
      if (op_mode == 0 || (op_mode == 2 && chance(50)))
         i_op_d = exu_op_pkg::alu_op_e'(next_rand() % 10);
      else
         i_op_d = exu_op_pkg::alu_op_e'(exu_op_pkg::BEQ + next_rand() % 7);
      i_gpr_rs1_d     = chance(40) ? (next_rand() & 32'h3) : next_rand();   // Small for equal
      i_gpr_rs2_d     = chance(40) ? (next_rand() & 32'h3) : next_rand();
      i_rs1_en_d      = chance(80);
      i_rs2_en_d      = chance(80);
      i_imm_d         = next_rand();
      i_use_imm_d     = chance(30);
      i_select_pc_d   = chance(15);
      r               = next_rand();
      i_rs1_byp_sel_d = chance(byp_pct) ? (4'b0001 << r[1:0]) : 4'b0000;
      i_rs2_byp_sel_d = chance(byp_pct) ? (4'b0001 << r[3:2]) : 4'b0000;
      i_result_r      = next_rand();
      i_lsu_result_m  = next_rand();
      i_nb_load_data  = next_rand();
      r               = next_rand();
      i_pc_d          = r[PW-1:0];
      r               = next_rand();
      i_br_imm_d      = r[IW-1:0];
      i_pred_taken_d  = chance(50);
      r               = next_rand();
      i_pred_target_d = chance(50) ? (i_pc_d + {{(PW-IW){i_br_imm_d[IW]}}, i_br_imm_d})
                                   : r[PW-1:0];
      r               = next_rand();
      i_pred_index_d  = r[7:0];
      i_pred_btag_d   = r[12:8];
      i_pred_fghr_d   = r[20:13];
      r               = next_rand();
      i_flush_lower_r = chance(flush_pct);
      i_flush_path_r  = r[PW-1:0];
   endtask

   initial begin
      i_rst_n = 1'b0;
      i_hold = 1'b0;
      i_valid_d = 1'b0;
      i_op_d = exu_op_pkg::ADD;
      {i_pc_d, i_br_imm_d, i_gpr_rs1_d, i_gpr_rs2_d, i_imm_d} = '0;
      {i_rs1_en_d, i_rs2_en_d, i_use_imm_d, i_select_pc_d} = '0;
      {i_rs1_byp_sel_d, i_rs2_byp_sel_d} = '0;
      {i_pred_taken_d, i_pred_target_d, i_pred_index_d, i_pred_btag_d, i_pred_fghr_d} = '0;
      {i_result_r, i_lsu_result_m, i_nb_load_data} = '0;
      {i_flush_lower_r, i_flush_path_r} = '0;
      repeat (RST_CYCLES) @(posedge clk);
      #2;
      i_rst_n = 1'b1;
      test_name = "alu_random";
      repeat (N_PHASE) issue_cycle(0, 0, 0, 0);
      test_name = "bypass";
      repeat (N_PHASE) issue_cycle(0, 70, 0, 0);
      test_name = "branch_mispredict";
      repeat (N_PHASE) issue_cycle(1, 20, 0, 0);
      test_name = "flush_lower";
      repeat (N_PHASE) issue_cycle(2, 20, 25, 0);
      test_name = "hold";
      repeat (N_PHASE) issue_cycle(2, 30, 10, 35);
      @(posedge clk);
      #2;
      {i_valid_d, i_hold, i_flush_lower_r} = '0;
      repeat (3) @(posedge clk);
      $display("Simulation passed");
      $finish;
   end

   initial begin
      #(TIMEOUT);
      $display("Watchdog expired after %0d ns with the run still going", TIMEOUT);
      $display("Simulation failed");
      $fatal(1, "timeout");
   end

endmodule

`default_nettype wire

//--- exu_top.f
exu_cfg_pkg.sv
exu_op_pkg.sv
exu_operand_sel.sv
exu_alu.sv
exu_branch_retire.sv
exu_top.sv
tb_exu_top.sv
